/* source/gb_bus_pkg.sv */
`default_nettype none

package gb_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [15:0] BOOT_END  = 16'h00FF; // Top of boot overlay
    localparam logic [15:0] CART_END  = 16'h7FFF; // Top of cartridge ROM
    localparam logic [15:0] CRAM_BASE = 16'hA000; // Cartridge RAM
    localparam logic [15:0] CRAM_END  = 16'hBFFF;
    localparam logic [15:0] WRAM_BASE = 16'hC000; // 8 KiB work RAM
    localparam logic [15:0] ECHO_BASE = 16'hE000; // Mirror of work RAM
    localparam logic [15:0] ECHO_END  = 16'hFDFF;
    localparam logic [15:0] OAM_BASE  = 16'hFE00; // Sprite attribute table
    localparam logic [15:0] OAM_END   = 16'hFE9F;
    localparam logic [15:0] HRAM_BASE = 16'hFF80; // High RAM
    localparam logic [15:0] HRAM_END  = 16'hFFFE;

    // Single byte registers
    localparam logic [15:0] MMIO_JOYP = 16'hFF00;
    localparam logic [15:0] MMIO_IF   = 16'hFF0F;
    localparam logic [15:0] MMIO_DMA  = 16'hFF46;
    localparam logic [15:0] MMIO_BOOT = 16'hFF50;
    localparam logic [15:0] MMIO_IE   = 16'hFFFF;

    localparam logic [7:0] DMA_LENGTH = 8'd160; // Bytes per OAM transfer

    // Bit positions in IF and IE
    localparam int INT_VBLANK = 0;
    localparam int INT_LCDC   = 1;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        REGION_BROM, REGION_CART, REGION_CRAM, REGION_WRAM,
        REGION_OAM,  REGION_HRAM, REGION_JOYP, REGION_IF,
        REGION_IE,   REGION_DMA,  REGION_BOOT, REGION_JUNK
    } mem_region_t;

    typedef enum logic {
        MASTER_CPU = 1'b0,
        MASTER_DMA = 1'b1
    } master_t;

    typedef enum logic [1:0] {
        DMA_IDLE, DMA_READ, DMA_WAIT, DMA_WRITE
    } dma_state_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        we;
        logic        re;
    } bus_req_t;

    typedef struct packed {
        bus_req_t req;
        master_t  master; // Who issued it
    } tagged_req_t;

    typedef struct packed {
        tagged_req_t treq;
        mem_region_t region;
        logic [12:0] offset; // Byte index inside region
    } decoded_req_t;

    typedef struct packed {
        logic       valid; // Read data present
        master_t    master;
        logic [7:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        wr;
        logic        rd;
        logic        cs; // External RAM select
    } cart_bus_t;

endpackage

`default_nettype wire

/* source/bus_master_select.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_master_select import gb_bus_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire bus_req_t cpu_req,    // CPU port, one cycle level
    input  wire           dma_start,  // Pulse from FF46 write
    input  wire [7:0]     dma_page,   // Source page
    input  wire bus_rsp_t bus_rsp,    // Stage 3 response
    output logic          cpu_stall,
    output tagged_req_t   master_req  // Stage 1 register
);

    dma_state_t  dma_state;
    logic [7:0]  dma_index;  // Byte being moved
    logic [7:0]  dma_data;   // Held between read and write
    logic [7:0]  dma_base;   // Page latched at start
    logic        rsp_hit;    // Our read came back
    tagged_req_t next_req;

    assign rsp_hit   = bus_rsp.valid && (bus_rsp.master == MASTER_DMA);
    assign cpu_stall = (dma_state != DMA_IDLE); // CPU locked out for whole transfer

    ////////////////////////////////////////////////////////////////////////////
    // OAM DMA sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            dma_state <= DMA_IDLE;
            dma_index <= '0;
        end else begin
            case (dma_state)
                DMA_IDLE: begin
                    if (dma_start) begin
                        dma_state <= DMA_READ;
                        dma_index <= '0;
                    end
                end
                DMA_READ: dma_state <= DMA_WAIT; // Read goes out this cycle
                DMA_WAIT: begin
                    // Latency depends on what is in flight ahead of us
                    if (rsp_hit) begin
                        dma_state <= DMA_WRITE;
                    end
                end
                DMA_WRITE: begin
                    if (dma_index == DMA_LENGTH - 8'd1) begin
                        dma_state <= DMA_IDLE; // Last byte issued
                    end else begin
                        dma_state <= DMA_READ;
                        dma_index <= dma_index + 8'd1;
                    end
                end
                default: dma_state <= DMA_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dma_state == DMA_IDLE && dma_start) begin
            dma_base <= dma_page;
        end
        if (dma_state == DMA_WAIT && rsp_hit) begin
            dma_data <= bus_rsp.rdata; // Byte for the OAM write
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Master selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_req = '0; // Empty slot by default
        case (dma_state)
            DMA_IDLE: begin
                next_req.req    = cpu_req;
                next_req.master = MASTER_CPU;
            end
            DMA_READ: begin
                next_req.req.addr = {dma_base, dma_index}; // page * 256 + index
                next_req.req.re   = 1'b1;
                next_req.master   = MASTER_DMA;
            end
            DMA_WRITE: begin
                next_req.req.addr  = OAM_BASE + {8'h00, dma_index};
                next_req.req.wdata = dma_data;
                next_req.req.we    = 1'b1;
                next_req.master    = MASTER_DMA;
            end
            default: ; // Waiting on read data
        endcase
    end

    // Stage 1 register, only the strobes are cleared
    always_ff @(posedge clk) begin
        master_req <= next_req;
        if (reset) begin
            master_req.req.we <= 1'b0;
            master_req.req.re <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/address_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module address_decode import gb_bus_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    input  wire tagged_req_t master_req, // From stage 1
    input  wire              boot_done,  // Overlay off once set
    output decoded_req_t     dec_req     // Stage 2 register
);

    logic [15:0] addr;
    logic [15:0] base;   // Start of the chosen region
    logic [15:0] span;   // addr minus base
    logic        boot_off;
    mem_region_t region;

    assign addr = master_req.req.addr;
    assign span = addr - base;

    // FF50 write sitting in stage 3 this cycle already drops the overlay
    assign boot_off = boot_done
                   || (dec_req.treq.req.we && dec_req.region == REGION_BOOT);

    always_comb begin
        region = REGION_JUNK; // VRAM, PPU, audio etc. land here
        base   = 16'h0000;
        if (addr <= BOOT_END && !boot_off) begin
            region = REGION_BROM;      // Overlay hides cart bytes 0000-00FF
        end else if (addr <= CART_END) begin
            region = REGION_CART;
        end else if (addr >= CRAM_BASE && addr <= CRAM_END) begin
            region = REGION_CRAM;
            base   = CRAM_BASE;
        end else if (addr >= WRAM_BASE && addr < ECHO_BASE) begin
            region = REGION_WRAM;
            base   = WRAM_BASE;
        end else if (addr >= ECHO_BASE && addr <= ECHO_END) begin
            region = REGION_WRAM;      // Echo folds onto work RAM
            base   = ECHO_BASE;
        end else if (addr >= OAM_BASE && addr <= OAM_END) begin
            region = REGION_OAM;
            base   = OAM_BASE;
        end else if (addr >= HRAM_BASE && addr <= HRAM_END) begin
            region = REGION_HRAM;
            base   = HRAM_BASE;
        end else begin
            case (addr)
                MMIO_JOYP: region = REGION_JOYP;
                MMIO_IF:   region = REGION_IF;
                MMIO_DMA:  region = REGION_DMA;
                MMIO_BOOT: region = REGION_BOOT;
                MMIO_IE:   region = REGION_IE;
                default:   region = REGION_JUNK;
            endcase
        end
    end

    // Stage 2 register
    always_ff @(posedge clk) begin
        dec_req.treq   <= master_req;
        dec_req.region <= region;
        dec_req.offset <= span[12:0]; // Largest region is 8 KiB
        if (reset) begin
            dec_req.treq.req.we <= 1'b0;
            dec_req.treq.req.re <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/memory_access.sv */
`timescale 1ns/10ps
`default_nettype none

module memory_access import gb_bus_pkg::*; (
    input  wire               clk,
    input  wire               reset,
    input  wire decoded_req_t dec_req,    // From stage 2
    input  wire [7:0]         cart_din,   // Cartridge read data
    input  wire [7:0]         key,        // Active low buttons
    input  wire               vblank_req,
    input  wire               lcdc_req,
    output bus_rsp_t          bus_rsp,    // Registered response
    output cart_bus_t         cart,
    output logic              boot_done,
    output logic              dma_start,
    output logic [7:0]        dma_page,
    output logic              irq_pending
);

    logic [7:0] wram [0:8191];
    logic [7:0] oam  [0:159];
    logic [7:0] hram [0:126];
    logic [7:0] brom [0:255];   // Read only

    bus_req_t    req;
    mem_region_t region;
    logic [12:0] ofs;
    logic [4:0]  if_q;
    logic [4:0]  if_next;
    logic [4:0]  ie_q;
    logic [1:0]  joyp_sel;  // Bits 5 and 4 of FF00
    logic [3:0]  joyp_nib;
    logic        cart_hit;

    assign req    = dec_req.treq.req;
    assign region = dec_req.region;
    assign ofs    = dec_req.offset;

    initial $readmemh("boot_rom.hex", brom);

    ////////////////////////////////////////////////////////////////////////////
    // Memory arrays
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (req.we) begin
            case (region)
                REGION_WRAM: wram[ofs]      <= req.wdata;
                REGION_OAM:  oam[ofs[7:0]]  <= req.wdata;
                REGION_HRAM: hram[ofs[6:0]] <= req.wdata;
                default: ; // Others are registers or ignore writes
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // MMIO registers
    ////////////////////////////////////////////////////////////////////////////

    // Bus write replaces IF, then pulses OR in on top
    always_comb begin
        if_next = (req.we && region == REGION_IF) ? req.wdata[4:0] : if_q;
        if_next[INT_VBLANK] = if_next[INT_VBLANK] | vblank_req;
        if_next[INT_LCDC]   = if_next[INT_LCDC] | lcdc_req;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            if_q      <= '0;
            ie_q      <= '0;
            joyp_sel  <= '0;
            boot_done <= 1'b0;   // Overlay on
            dma_start <= 1'b0;
        end else begin
            if_q <= if_next;
            if (req.we && region == REGION_IE) begin
                ie_q <= req.wdata[4:0];
            end
            if (req.we && region == REGION_JOYP) begin
                joyp_sel <= req.wdata[5:4];
            end
            if (req.we && region == REGION_BOOT) begin
                boot_done <= 1'b1; // Sticky until reset
            end
            dma_start <= req.we && (region == REGION_DMA); // One cycle
        end
    end

    always_ff @(posedge clk) begin
        if (req.we && region == REGION_DMA) begin
            dma_page <= req.wdata;
        end
    end

    // Low select bit picks a key group, both low ANDs them
    assign joyp_nib = (joyp_sel[0] ? 4'hF : key[3:0]) & (joyp_sel[1] ? 4'hF : key[7:4]);

    assign irq_pending = |(if_q & ie_q);

    ////////////////////////////////////////////////////////////////////////////
    // Read response
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        bus_rsp.master <= dec_req.treq.master;
        case (region)
            REGION_BROM: bus_rsp.rdata <= brom[ofs[7:0]];
            REGION_CART: bus_rsp.rdata <= cart_din;     // Sampled end of N+2
            REGION_CRAM: bus_rsp.rdata <= cart_din;
            REGION_WRAM: bus_rsp.rdata <= wram[ofs];
            REGION_OAM:  bus_rsp.rdata <= oam[ofs[7:0]];
            REGION_HRAM: bus_rsp.rdata <= hram[ofs[6:0]];
            REGION_JOYP: bus_rsp.rdata <= {2'b11, joyp_sel, joyp_nib};
            REGION_IF:   bus_rsp.rdata <= {3'b000, if_q};
            REGION_IE:   bus_rsp.rdata <= {3'b000, ie_q};
            REGION_DMA:  bus_rsp.rdata <= dma_page;
            REGION_BOOT: bus_rsp.rdata <= {7'd0, boot_done};
            default:     bus_rsp.rdata <= 8'h00;        // Junk reads as zero
        endcase
        bus_rsp.valid <= req.re;
        if (reset) begin
            bus_rsp.valid <= 1'b0;
        end
    end

    // Cartridge port straight off the stage 2 register
    assign cart_hit = (region == REGION_CART) || (region == REGION_CRAM);

    always_comb begin
        cart.addr  = req.addr;
        cart.wdata = req.wdata;
        cart.wr    = req.we && cart_hit;
        cart.rd    = req.re && cart_hit;
        cart.cs    = (req.we || req.re) && (region == REGION_CRAM); // External RAM only
    end

endmodule

`default_nettype wire

/* source/gb_bus_top.sv */
`timescale 1ns/10ps
`default_nettype none

module gb_bus_top import gb_bus_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire bus_req_t cpu_req,
    output logic          cpu_stall,   // CPU must hold its request
    output bus_rsp_t      cpu_rsp,
    output cart_bus_t     cart,
    input  wire [7:0]     cart_din,
    input  wire [7:0]     key,
    input  wire           vblank_req,
    input  wire           lcdc_req,
    output logic          irq_pending
);

    tagged_req_t  master_req;  // Stage 1 to 2
    decoded_req_t dec_req;     // Stage 2 to 3
    bus_rsp_t     bus_rsp;     // Stage 3 out, also fed back to DMA
    logic         boot_done;
    logic         dma_start;
    logic [7:0]   dma_page;

    bus_master_select u_stage1 (
        .clk        (clk),
        .reset      (reset),
        .cpu_req    (cpu_req),
        .dma_start  (dma_start),
        .dma_page   (dma_page),
        .bus_rsp    (bus_rsp),
        .cpu_stall  (cpu_stall),
        .master_req (master_req)
    );

    address_decode u_stage2 (
        .clk        (clk),
        .reset      (reset),
        .master_req (master_req),
        .boot_done  (boot_done),
        .dec_req    (dec_req)
    );

    memory_access u_stage3 (
        .clk         (clk),
        .reset       (reset),
        .dec_req     (dec_req),
        .cart_din    (cart_din),
        .key         (key),
        .vblank_req  (vblank_req),
        .lcdc_req    (lcdc_req),
        .bus_rsp     (bus_rsp),
        .cart        (cart),
        .boot_done   (boot_done),
        .dma_start   (dma_start),
        .dma_page    (dma_page),
        .irq_pending (irq_pending)
    );

    // DMA reads stay internal
    always_comb begin
        cpu_rsp       = bus_rsp;
        cpu_rsp.valid = bus_rsp.valid && (bus_rsp.master == MASTER_CPU);
    end

endmodule

`default_nettype wire

/* verification/gb_bus_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module gb_bus_properties import gb_bus_pkg::*; (
    input wire            clk,
    input wire            reset,
    input wire bus_req_t  cpu_req,
    input wire            cpu_stall,
    input wire bus_rsp_t  cpu_rsp,
    input wire cart_bus_t cart,
    input wire            irq_pending
);

    int   fail_count = 0;      // Assertion failures so far
    logic cpu_read_accepted;   // Read taken by stage 1 this cycle

    assign cpu_read_accepted = cpu_req.re && !cpu_stall && !reset;

    ////////////////////////////////////////////////////////////////////////////
    // Response timing
    ////////////////////////////////////////////////////////////////////////////

    a_read_latency: assert property (@(posedge clk) disable iff (reset)
        cpu_read_accepted |-> ##3 cpu_rsp.valid)
    else begin
        $error("CPU read gave no cpu_rsp.valid three cycles later");
        fail_count++;
    end

    a_no_stray_valid: assert property (@(posedge clk) disable iff (reset)
        cpu_rsp.valid |-> $past(cpu_read_accepted, 3))
    else begin
        $error("cpu_rsp.valid high without a CPU read three cycles before");
        fail_count++;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Strobes
    ////////////////////////////////////////////////////////////////////////////

    a_cart_rd_wr: assert property (@(posedge clk) !(cart.rd && cart.wr))
    else begin
        $error("cart.rd and cart.wr high together");
        fail_count++;
    end

    // First cycle out of reset
    a_reset_state: assert property (@(posedge clk) $fell(reset) |->
        !cpu_stall && !cart.rd && !cart.wr && !cart.cs && !irq_pending)
    else begin
        $error("Outputs not idle in the cycle after reset");
        fail_count++;
    end

endmodule

bind gb_bus_top gb_bus_properties u_props (
    .clk         (clk),
    .reset       (reset),
    .cpu_req     (cpu_req),
    .cpu_stall   (cpu_stall),
    .cpu_rsp     (cpu_rsp),
    .cart        (cart),
    .irq_pending (irq_pending)
);

`default_nettype wire

/* verification/gb_bus_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module gb_bus_tb import gb_bus_pkg::*; ();

    // Rough cycle budget per test, DMA counted at 8 cycles per byte
    localparam int BOOT_CYCLES     = 256 + 16 * 3 + 40;
    localparam int RAND_CYCLES     = 64 * 3 + 40;
    localparam int JOYP_CYCLES     = 4 * (4 * 12 + 4);
    localparam int IRQ_CYCLES      = 200;
    localparam int DMA_LIMIT       = 160 * 8;
    localparam int DMA_CYCLES      = 160 * 2 + DMA_LIMIT + 160 + 60;
    localparam int CART_CYCLES     = 4 * 4;
    localparam int WATCHDOG_CYCLES = BOOT_CYCLES + RAND_CYCLES + JOYP_CYCLES + IRQ_CYCLES
                                   + DMA_CYCLES + CART_CYCLES + 500;

    logic       clk;
    logic       reset;
    bus_req_t   cpu_req;
    logic       cpu_stall;
    bus_rsp_t   cpu_rsp;
    cart_bus_t  cart;
    logic [7:0] cart_din;
    logic [7:0] key;
    logic       vblank_req;
    logic       lcdc_req;
    logic       irq_pending;

    // Reference model state
    logic [7:0] m_wram [0:8191];
    logic [7:0] m_oam  [0:159];
    logic [7:0] m_hram [0:126];
    logic [7:0] m_brom [0:255];
    logic [4:0] m_if;
    logic [4:0] m_ie;
    logic [1:0] m_sel;       // FF00 bits 5..4
    logic       m_boot;
    logic [7:0] m_dma;

    logic [7:0]  exp_q [$];  // Expected read data, in issue order
    logic [15:0] addr_q [$];
    logic [7:0]  exp_data;
    logic [15:0] exp_addr;
    logic [31:0] rnd;
    integer      seed = 32'h1f95_4c0a;
    int          errors = 0;
    int          test_errors;
    int          tests_passed = 0;
    int          tests_failed = 0;

    assign cart_din = cart.addr[7:0]; // Cartridge returns its low address byte

    gb_bus_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .cpu_stall   (cpu_stall),
        .cpu_rsp     (cpu_rsp),
        .cart        (cart),
        .cart_din    (cart_din),
        .key         (key),
        .vblank_req  (vblank_req),
        .lcdc_req    (lcdc_req),
        .irq_pending (irq_pending)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [3:0] joyp_nibble(input logic [1:0] sel, input logic [7:0] k);
        case (sel)
            2'b00:   return k[3:0] & k[7:4];
            2'b10:   return k[3:0];  // Bit 4 low, directions
            2'b01:   return k[7:4];  // Bit 5 low, buttons
            default: return 4'hF;
        endcase
    endfunction

    function automatic logic [7:0] model_read(input logic [15:0] a);
        if (a <= BOOT_END && !m_boot) return m_brom[a[7:0]];
        if (a <= CART_END) return a[7:0];
        if (a >= CRAM_BASE && a <= CRAM_END) return a[7:0];
        if (a >= WRAM_BASE && a <= ECHO_END) return m_wram[a[12:0]]; // Echo shares low bits
        if (a >= OAM_BASE && a <= OAM_END) return m_oam[a[7:0]];
        if (a >= HRAM_BASE && a <= HRAM_END) return m_hram[a[6:0]];
        if (a == MMIO_JOYP) return {2'b11, m_sel, joyp_nibble(m_sel, key)};
        if (a == MMIO_IF) return {3'b000, m_if};
        if (a == MMIO_IE) return {3'b000, m_ie};
        if (a == MMIO_DMA) return m_dma;
        return 8'h00;
    endfunction

    task automatic model_write(input logic [15:0] a, input logic [7:0] d);
        if (a >= WRAM_BASE && a <= ECHO_END)
            m_wram[a[12:0]] = d;
        else if (a >= OAM_BASE && a <= OAM_END)
            m_oam[a[7:0]] = d;
        else if (a >= HRAM_BASE && a <= HRAM_END)
            m_hram[a[6:0]] = d;
        else if (a == MMIO_JOYP)
            m_sel = d[5:4];
        else if (a == MMIO_IF)
            m_if = d[4:0];
        else if (a == MMIO_IE)
            m_ie = d[4:0];
        else if (a == MMIO_BOOT)
            m_boot = 1'b1;
        else if (a == MMIO_DMA) begin
            m_dma = d;
            for (int k = 0; k < 160; k++) begin
                m_oam[k] = model_read({d, k[7:0]}); // Whole transfer at once
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus tasks, called on a falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_request(input logic [15:0] a, input logic [7:0] d,
                                 input logic we, input logic re);
        cpu_req.addr  = a;
        cpu_req.wdata = d;
        cpu_req.we    = we;
        cpu_req.re    = re;
        @(negedge clk);
        cpu_req = '0;
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        model_write(a, d);
        drive_request(a, d, 1'b1, 1'b0);
    endtask

    task automatic bus_read(input logic [15:0] a);
        exp_q.push_back(model_read(a));
        addr_q.push_back(a);
        drive_request(a, 8'h00, 1'b0, 1'b1);
    endtask

    task automatic wait_responses();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Read response missing for address %h", addr_q[0]);
            errors++;
            exp_q.delete();
            addr_q.delete();
        end
        repeat (3) @(negedge clk); // Trailing writes land
    endtask

    // Read data checked mid cycle, one cycle after stage 3 registers it
    always @(negedge clk) begin
        if (!reset && cpu_rsp.valid) begin
            if (exp_q.size() == 0) begin
                $display("Read response arrived with no read outstanding");
                errors++;
            end else begin
                exp_data = exp_q.pop_front();
                exp_addr = addr_q.pop_front();
                assert (cpu_rsp.rdata == exp_data) else begin
                    $display("ERROR cpu_rsp.rdata at %h expected %h got %h",
                             exp_addr, exp_data, cpu_rsp.rdata);
                    errors++;
                end
            end
        end
    end

    task automatic check_cart_read(input logic [15:0] a);
        bus_read(a);
        @(negedge clk); // Cycle N+2
        assert (cart.rd && !cart.wr && cart.addr == a) else begin
            $display("ERROR cart.rd/cart.addr expected 1/%h got %h/%h", a, cart.rd, cart.addr);
            errors++;
        end
    endtask

    task automatic check_cart_write(input logic [15:0] a, input logic [7:0] d);
        bus_write(a, d);
        @(negedge clk);
        assert (cart.cs && cart.wr && cart.addr == a && cart.wdata == d) else begin
            $display("ERROR cart cs/wr/addr/wdata expected 1/1/%h/%h got %h/%h/%h/%h",
                     a, d, cart.cs, cart.wr, cart.addr, cart.wdata);
            errors++;
        end
    endtask

    task automatic pulse_interrupts(input logic v, input logic l);
        vblank_req = v;
        lcdc_req   = l;
        @(negedge clk);
        vblank_req = 1'b0;
        lcdc_req   = 1'b0;
        m_if[INT_VBLANK] = m_if[INT_VBLANK] | v;
        m_if[INT_LCDC]   = m_if[INT_LCDC] | l;
    endtask

    task automatic check_irq_line();
        assert (irq_pending == |(m_if & m_ie)) else begin
            $display("ERROR irq_pending expected %h got %h", |(m_if & m_ie), irq_pending);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, errors - test_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [15:0] a;
        logic [15:0] alias_a;
        int          n;
        reset      = 1'b1;
        cpu_req    = '0;
        key        = 8'hFF;   // Nothing pressed
        vblank_req = 1'b0;
        lcdc_req   = 1'b0;
        m_if   = '0;
        m_ie   = '0;
        m_sel  = '0;
        m_boot = 1'b0;
        m_dma  = 8'h00;
        $readmemh("boot_rom.hex", m_brom);
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        begin_test();          // Boot overlay then cartridge underneath
        for (a = 16'h0000; a <= BOOT_END; a++) bus_read(a);
        wait_responses();
        bus_write(MMIO_BOOT, 8'h01);
        for (a = 16'h0003; a <= BOOT_END; a += 16'd17) check_cart_read(a);
        wait_responses();
        end_test("boot overlay");

        begin_test();
        for (int i = 0; i < 64; i++) begin
            rnd = $random(seed);
            case (rnd[31:30])
                2'd0:    a = WRAM_BASE + {3'b000, rnd[12:0]};
                2'd1:    a = ECHO_BASE + {3'b000, rnd[12:0] % 13'h1E00};
                default: a = HRAM_BASE + {9'd0, rnd[22:16] % 7'd127};
            endcase
            if (a[15:13] == 3'b110 && a[12:0] < 13'h1E00) alias_a = a + 16'h2000;
            else if (a[15:13] == 3'b111 && a < OAM_BASE) alias_a = a - 16'h2000;
            else alias_a = a;
            rnd = $random(seed);
            bus_write(a, rnd[7:0]);
            bus_read(alias_a);     // Back to back, through the mirror where one exists
            if (i % 16 == 0) bus_read(16'hFF40);
        end
        wait_responses();
        end_test("random RAM");

        begin_test();
        for (int s = 0; s < 4; s++) begin
            bus_write(MMIO_JOYP, {2'b00, s[1:0], 4'h0});
            for (int j = 0; j < 4; j++) begin
                rnd = $random(seed);
                key = rnd[7:0];    // Held until the read completes
                bus_read(MMIO_JOYP);
                wait_responses();
            end
        end
        key = 8'hFF;
        end_test("joypad");

        begin_test();
        pulse_interrupts(1'b1, 1'b0);
        bus_read(MMIO_IF);
        wait_responses();          // IF sampled in stage 3, keep later pulses out
        pulse_interrupts(1'b0, 1'b1);
        bus_read(MMIO_IF);
        bus_write(MMIO_IF, 8'hE4); // Upper bits dropped
        bus_read(MMIO_IF);
        bus_write(MMIO_IE, 8'h01);
        wait_responses();
        check_irq_line();
        bus_write(MMIO_IE, 8'hFD);
        bus_read(MMIO_IE);
        wait_responses();
        check_irq_line();
        pulse_interrupts(1'b1, 1'b0);
        check_irq_line();
        bus_write(MMIO_IF, 8'h00);
        wait_responses();
        check_irq_line();
        end_test("interrupts");

        begin_test();
        for (int i = 0; i < 160; i++) begin
            rnd = $random(seed);
            bus_write({8'hC1, i[7:0]}, rnd[7:0]);
        end
        bus_write(MMIO_DMA, 8'hC1);
        n = 0;
        while (!cpu_stall && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!cpu_stall) begin
            $display("cpu_stall never rose after the DMA register write");
            errors++;
        end
        n = 0;
        while (cpu_stall && n < DMA_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (cpu_stall) begin
            $display("cpu_stall still high after %0d cycles of DMA", DMA_LIMIT);
            errors++;
        end
        for (int i = 0; i < 160; i++) bus_read(OAM_BASE + {8'h00, i[7:0]});
        wait_responses();
        end_test("OAM DMA");

        begin_test();
        for (int j = 0; j < 4; j++) begin
            rnd = $random(seed);
            check_cart_write(CRAM_BASE + {3'b000, rnd[12:0]}, rnd[23:16]);
        end
        wait_responses();
        end_test("cart RAM write");

        errors += u_dut.u_props.fail_count;
        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
source/gb_bus_pkg.sv
source/bus_master_select.sv
source/address_decode.sv
source/memory_access.sv
source/gb_bus_top.sv
verification/gb_bus_properties.sv
verification/gb_bus_tb.sv

/* boot_rom.hex */
// Boot ROM image, 16 bytes per row, row n holds addresses n*16 to n*16+15
// Each byte is FF minus its address
FF FE FD FC FB FA F9 F8 F7 F6 F5 F4 F3 F2 F1 F0
EF EE ED EC EB EA E9 E8 E7 E6 E5 E4 E3 E2 E1 E0
DF DE DD DC DB DA D9 D8 D7 D6 D5 D4 D3 D2 D1 D0
CF CE CD CC CB CA C9 C8 C7 C6 C5 C4 C3 C2 C1 C0
BF BE BD BC BB BA B9 B8 B7 B6 B5 B4 B3 B2 B1 B0
AF AE AD AC AB AA A9 A8 A7 A6 A5 A4 A3 A2 A1 A0
9F 9E 9D 9C 9B 9A 99 98 97 96 95 94 93 92 91 90
8F 8E 8D 8C 8B 8A 89 88 87 86 85 84 83 82 81 80
7F 7E 7D 7C 7B 7A 79 78 77 76 75 74 73 72 71 70
6F 6E 6D 6C 6B 6A 69 68 67 66 65 64 63 62 61 60
5F 5E 5D 5C 5B 5A 59 58 57 56 55 54 53 52 51 50
4F 4E 4D 4C 4B 4A 49 48 47 46 45 44 43 42 41 40
3F 3E 3D 3C 3B 3A 39 38 37 36 35 34 33 32 31 30
2F 2E 2D 2C 2B 2A 29 28 27 26 25 24 23 22 21 20
1F 1E 1D 1C 1B 1A 19 18 17 16 15 14 13 12 11 10
0F 0E 0D 0C 0B 0A 09 08 07 06 05 04 03 02 01 00
